// File: source/mipsHazard_params.svh
// MIPS decode-side constants: opcodes, function codes, exception vector and NOP word
`ifndef MIPS_HAZARD_PARAMS_SVH
`define MIPS_HAZARD_PARAMS_SVH

// primary opcodes, instr[31:26]
`define OP_RTYPE 6'h00 // funct selects the ALU op
`define OP_J     6'h02
`define OP_BEQ   6'h04
`define OP_BNE   6'h05
`define OP_ADDI  6'h08
`define OP_LW    6'h23
`define OP_SW    6'h2b

// R-type function codes in use, instr[5:0]
`define FN_ADD   6'h20
`define FN_SUB   6'h22
`define FN_OR    6'h25
`define FN_SLT   6'h2a

`define IRQ_VECTOR 32'h8000_0180 // exception entry
`define NOP_INSTR  32'h0000_0000 // sll $0,$0,0

`endif

// File: source/mipsIsaPkg.sv
// MIPS ISA field types for instruction words, register numbers and immediates
package mipsIsaPkg;

  typedef logic [31:0] instrT; // full instruction word

  typedef logic [31:0] addrT; // byte address, pc and targets

  typedef logic [31:0] wordT; // register file data

  typedef logic [4:0] regAddrT; // rs / rt / rd number

  typedef logic [5:0] opcodeT; // instr[31:26]

  typedef logic [5:0] functT; // instr[5:0], R-type only

  typedef logic [4:0] shamtT; // instr[10:6]

  typedef logic [15:0] immT; // I-type immediate / branch offset

  typedef logic [25:0] jIdxT; // J-type word index

  // field positions, shared so decode and the model slice the same bits
  localparam int OpMsb = 31;
  localparam int RsLsb = 21;
  localparam int RtLsb = 16;
  localparam int RdLsb = 11;

endpackage

// File: source/pipeCtrlPkg.sv
// pipeline control types: decoded control word and hazard cause codes
package pipeCtrlPkg;

  // decoded control bits travelling with an instruction
  typedef struct packed {
    logic regWrite; // writes a GPR
    logic memRd;    // load
    logic memWr;    // store
    logic regDst;   // 1 -> dest is rd, 0 -> rt
    logic branch;   // beq / bne
    logic jump;     // j
  } ctrlT;

  // why the hazard unit acted this cycle
  typedef enum logic [2:0] {
    none        = 3'd0,
    loadUse     = 3'd1, // stall behind a load
    regBranch   = 3'd2, // branch waits for its operand
    jump        = 3'd3,
    irq         = 3'd4,
    branchTaken = 3'd5
  } hazardT;

endpackage

// File: source/pipeIfs.sv
// stage-register buses from IF/ID and ID/EX toward decode and the hazard unit
`timescale 1ns/1ps

interface ifIdBus;
  logic                 valid; // 0 on a bubble
  mipsIsaPkg::instrT    instr;
  mipsIsaPkg::addrT     pc;
  mipsIsaPkg::regAddrT  rs;    // instr[25:21]
  mipsIsaPkg::regAddrT  rt;    // instr[20:16]

  modport source (
    output valid, instr, pc, rs, rt
  );

  modport sink (
    input valid, instr, pc, rs, rt
  );
endinterface

interface idExBus;
  logic                 valid;
  logic                 memRd;    // load in EX
  logic                 regWrite;
  logic                 regDst;   // picks rd over rt
  mipsIsaPkg::regAddrT  rt;
  mipsIsaPkg::regAddrT  rd;

  modport source (
    output valid, memRd, regWrite, regDst, rt, rd
  );

  modport sink (
    input valid, memRd, regWrite, regDst, rt, rd
  );
endinterface

// File: source/ifIdReg.sv
// IF/ID stage register: captures the fetched word, holds on stall, flushes to a bubble
`timescale 1ns/1ps
`include "mipsHazard_params.svh"

module ifIdReg (
  input  logic              clk,
  input  logic              rstN,
  input  mipsIsaPkg::instrT fetchInstr,
  input  mipsIsaPkg::addrT  fetchPc,
  input  logic              hold,  // stall, keep contents
  input  logic              clear, // flush, load bubble
  ifIdBus.source            ifId
);

  logic              validQ;
  mipsIsaPkg::instrT instrQ;
  mipsIsaPkg::addrT  pcQ;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      validQ <= 1'b0;
      instrQ <= `NOP_INSTR;
      pcQ    <= '0;
    end else if (clear) begin // clear wins, hazard unit never sets both
      validQ <= 1'b0;
      instrQ <= `NOP_INSTR;
      pcQ    <= '0;
    end else if (!hold) begin
      validQ <= 1'b1;
      instrQ <= fetchInstr;
      pcQ    <= fetchPc;
    end
  end

  assign ifId.valid = validQ;
  assign ifId.instr = instrQ;
  assign ifId.pc    = pcQ;
  assign ifId.rs    = instrQ[mipsIsaPkg::RsLsb +: 5]; // source regs straight from the word
  assign ifId.rt    = instrQ[mipsIsaPkg::RtLsb +: 5];

  // flush and stall come from one priority chain in the hazard unit
  clearHoldExcl: assert property (@(posedge clk) disable iff (!rstN)
    !(clear && hold))
    else $error("ifIdReg: clear and hold both set");

endmodule

// File: source/idDecode.sv
// ID decode: control bits from the opcode, beq/bne resolution and redirect targets
`timescale 1ns/1ps
`include "mipsHazard_params.svh"

module idDecode (
  ifIdBus.sink                ifId,
  input  mipsIsaPkg::wordT    rsData,
  input  mipsIsaPkg::wordT    rtData,
  output pipeCtrlPkg::ctrlT   ctrl,
  output mipsIsaPkg::regAddrT rd,
  output logic                branchTaken,
  output mipsIsaPkg::addrT    jumpTarget,
  output mipsIsaPkg::addrT    branchTarget
);

  mipsIsaPkg::opcodeT opcode;
  mipsIsaPkg::immT    imm;
  mipsIsaPkg::jIdxT   jIdx;
  mipsIsaPkg::addrT   pcPlus4;
  logic               operandsEq;

  assign opcode  = ifId.instr[mipsIsaPkg::OpMsb -: 6];
  assign imm     = ifId.instr[15:0];
  assign jIdx    = ifId.instr[25:0];
  assign rd      = ifId.instr[mipsIsaPkg::RdLsb +: 5];
  assign pcPlus4 = ifId.pc + 32'd4;

  always_comb begin
    ctrl = '0; // bubble or unknown opcode
    if (ifId.valid) begin
      case (opcode)
        `OP_RTYPE: begin
          ctrl.regWrite = 1'b1;
          ctrl.regDst   = 1'b1; // writes rd
        end
        `OP_LW: begin
          ctrl.regWrite = 1'b1;
          ctrl.memRd    = 1'b1;
        end
        `OP_ADDI: ctrl.regWrite = 1'b1;
        `OP_SW:   ctrl.memWr    = 1'b1;
        `OP_BEQ,
        `OP_BNE:  ctrl.branch   = 1'b1;
        `OP_J:    ctrl.jump     = 1'b1;
        default:  ctrl          = '0;
      endcase
    end
  end

  // compare in ID so the branch resolves one stage early
  assign operandsEq  = (rsData == rtData);
  assign branchTaken = ctrl.branch && ((opcode == `OP_BNE) ? !operandsEq : operandsEq);

  assign jumpTarget   = {pcPlus4[31:28], jIdx, 2'b00}; // pseudo-direct
  assign branchTarget = pcPlus4 + {{14{imm[15]}}, imm, 2'b00};

endmodule

// File: source/idExReg.sv
// ID/EX stage register holding control bits and destination numbers, bubble on clear
`timescale 1ns/1ps

module idExReg (
  input  logic                clk,
  input  logic                rstN,
  input  logic                clear,   // load bubble
  input  pipeCtrlPkg::ctrlT   ctrlIn,
  input  mipsIsaPkg::regAddrT rtIn,
  input  mipsIsaPkg::regAddrT rdIn,
  input  mipsIsaPkg::addrT    pcIn,
  input  logic                validIn,
  idExBus.source              idEx,
  output mipsIsaPkg::addrT    exPc
);

  logic                validQ;
  logic                memRdQ;
  logic                regWriteQ;
  logic                regDstQ;
  mipsIsaPkg::regAddrT rtQ;
  mipsIsaPkg::regAddrT rdQ;
  mipsIsaPkg::addrT    pcQ;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      validQ    <= 1'b0;
      memRdQ    <= 1'b0;
      regWriteQ <= 1'b0;
      regDstQ   <= 1'b0;
      rtQ       <= '0;
      rdQ       <= '0;
      pcQ       <= '0;
    end else if (clear) begin // a bubble writes nothing and loads nothing
      validQ    <= 1'b0;
      memRdQ    <= 1'b0;
      regWriteQ <= 1'b0;
      regDstQ   <= 1'b0;
      rtQ       <= '0;
      rdQ       <= '0;
      pcQ       <= '0;
    end else begin
      validQ    <= validIn;
      memRdQ    <= ctrlIn.memRd;
      regWriteQ <= ctrlIn.regWrite;
      regDstQ   <= ctrlIn.regDst;
      rtQ       <= rtIn;
      rdQ       <= rdIn;
      pcQ       <= pcIn;
    end
  end

  assign idEx.valid    = validQ;
  assign idEx.memRd    = memRdQ;
  assign idEx.regWrite = regWriteQ;
  assign idEx.regDst   = regDstQ;
  assign idEx.rt       = rtQ;
  assign idEx.rd       = rdQ;
  assign exPc          = pcQ;

  // load-use detection relies on a load always naming a destination
  loadWrites: assert property (@(posedge clk) disable iff (!rstN)
    memRdQ |-> regWriteQ)
    else $error("idExReg: memRd without regWrite");

endmodule

// File: source/hazardUnit.sv
// hazard unit driving flush and stall for load-use, register-branch, jump and interrupt cases
`timescale 1ns/1ps

module hazardUnit (
  ifIdBus.sink               ifId,
  idExBus.sink               idEx,
  input  pipeCtrlPkg::ctrlT  ctrl,        // decoded ID instruction
  input  logic               branchTaken,
  input  logic               irq,
  output logic               idExClear,
  output logic               ifIdClear,
  output logic               ifIdHold,
  output pipeCtrlPkg::hazardT cause
);

  mipsIsaPkg::regAddrT exDest;
  logic                loadUseHit;
  logic                regBranchHit;
  logic                stallHit;

  assign exDest = idEx.regDst ? idEx.rd : idEx.rt; // reg 0 compared too

  // load in EX feeds a source of the ID instruction
  assign loadUseHit = ifId.valid && idEx.valid && idEx.memRd &&
                      ((idEx.rt == ifId.rs) || (idEx.rt == ifId.rt));

  // branch compares in ID, so any pending write to its operands must land first
  assign regBranchHit = ctrl.branch && idEx.valid && idEx.regWrite &&
                        ((exDest == ifId.rs) || (exDest == ifId.rt));

  assign stallHit = loadUseHit || regBranchHit;

  always_comb begin
    idExClear = stallHit && !ctrl.jump; // jump never bubbles ID/EX
    // a stall keeps the ID instruction, irq or taken branch retries next cycle
    ifIdClear = !stallHit && (ctrl.jump || irq || branchTaken);
    ifIdHold  = idExClear;

    if (idExClear && loadUseHit) begin
      cause = pipeCtrlPkg::loadUse;
    end else if (idExClear) begin
      cause = pipeCtrlPkg::regBranch;
    end else if (ifIdClear && ctrl.jump) begin
      cause = pipeCtrlPkg::jump;
    end else if (ifIdClear && irq) begin
      cause = pipeCtrlPkg::irq;
    end else if (ifIdClear) begin
      cause = pipeCtrlPkg::branchTaken;
    end else begin
      cause = pipeCtrlPkg::none;
    end

    // decode never flags branch and jump together and takes only real branches
    decodeConsistent: assert final (!(ctrl.branch && ctrl.jump) &&
                                    (!branchTaken || ctrl.branch))
      else $error("hazardUnit: inconsistent decode inputs");
  end

endmodule

// File: source/mipsHazardTop.sv
// decode-side pipeline top: IF/ID and ID/EX registers, decode and hazard control
`timescale 1ns/1ps
`include "mipsHazard_params.svh"

module mipsHazardTop (
  input  logic                clk,
  input  logic                rstN,
  input  mipsIsaPkg::instrT   fetchInstr,
  input  mipsIsaPkg::addrT    fetchPc,
  input  mipsIsaPkg::wordT    rsData,     // regfile read of ID rs
  input  mipsIsaPkg::wordT    rtData,
  input  logic                irq,
  output logic                fetchStall, // present same fetch again
  output logic                redirect,
  output mipsIsaPkg::addrT    redirectPc,
  output mipsIsaPkg::addrT    exPc,
  output logic                exRegWrite,
  output logic                exMemRd,
  output mipsIsaPkg::regAddrT exWriteReg,
  output pipeCtrlPkg::hazardT hazardCause
);

  ifIdBus ifIdIf ();
  idExBus idExIf ();

  pipeCtrlPkg::ctrlT   ctrl;
  mipsIsaPkg::regAddrT rdDec;
  mipsIsaPkg::addrT    jumpTarget;
  mipsIsaPkg::addrT    branchTarget;
  logic                branchTaken;
  logic                idExClear;
  logic                ifIdClear;
  logic                ifIdHold;

  ifIdReg uIfId (.clk(clk), .rstN(rstN), .fetchInstr(fetchInstr), .fetchPc(fetchPc),
                 .hold(ifIdHold), .clear(ifIdClear), .ifId(ifIdIf.source));

  idDecode uDecode (.ifId(ifIdIf.sink), .rsData(rsData), .rtData(rtData), .ctrl(ctrl),
                    .rd(rdDec), .branchTaken(branchTaken), .jumpTarget(jumpTarget),
                    .branchTarget(branchTarget));

  idExReg uIdEx (.clk(clk), .rstN(rstN), .clear(idExClear), .ctrlIn(ctrl),
                 .rtIn(ifIdIf.rt), .rdIn(rdDec), .pcIn(ifIdIf.pc), .validIn(ifIdIf.valid),
                 .idEx(idExIf.source), .exPc(exPc));

  hazardUnit uHazard (.ifId(ifIdIf.sink), .idEx(idExIf.sink), .ctrl(ctrl),
                      .branchTaken(branchTaken), .irq(irq), .idExClear(idExClear),
                      .ifIdClear(ifIdClear), .ifIdHold(ifIdHold), .cause(hazardCause));

  assign fetchStall = ifIdHold;
  assign redirect   = ifIdClear; // flushing IF/ID means fetch went the wrong way

  always_comb begin
    if (ctrl.jump) begin
      redirectPc = jumpTarget; // jump outranks a coincident irq
    end else if (irq) begin
      redirectPc = `IRQ_VECTOR;
    end else begin
      redirectPc = branchTarget;
    end
  end

  assign exRegWrite = idExIf.regWrite;
  assign exMemRd    = idExIf.memRd;
  assign exWriteReg = idExIf.regDst ? idExIf.rd : idExIf.rt;

endmodule

// File: verification/hazardTb.sv
// random instruction stream checked against a pipeline model of the decode-side hazard control
`timescale 1ns/1ps
`include "mipsHazard_params.svh"

module hazardTb;

  localparam int          NumCycles     = 2000;
  localparam int          ResetCycles   = 3;
  localparam int          TimeoutCycles = NumCycles + ResetCycles + 97; // margin past the run
  localparam int unsigned Seed          = 32'h7435_217c;

  logic                clk;
  logic                rstN;
  mipsIsaPkg::instrT   fetchInstr;
  mipsIsaPkg::addrT    fetchPc;
  mipsIsaPkg::wordT    rsData;
  mipsIsaPkg::wordT    rtData;
  logic                irq;
  logic                fetchStall;
  logic                redirect;
  mipsIsaPkg::addrT    redirectPc;
  mipsIsaPkg::addrT    exPc;
  logic                exRegWrite;
  logic                exMemRd;
  mipsIsaPkg::regAddrT exWriteReg;
  pipeCtrlPkg::hazardT hazardCause;

  // model copies of the two stage registers
  logic                mIfValid;
  mipsIsaPkg::instrT   mIfInstr;
  mipsIsaPkg::addrT    mIfPc;
  logic                mExValid;
  logic                mExMemRd;
  logic                mExRegWrite;
  logic                mExRegDst;
  mipsIsaPkg::regAddrT mExRt;
  mipsIsaPkg::regAddrT mExRd;
  mipsIsaPkg::addrT    mExPc;

  // model decisions for the current cycle
  logic                expIdExClear;
  logic                expIfIdClear;
  logic                expHold;
  mipsIsaPkg::addrT    expRedirPc;
  pipeCtrlPkg::hazardT expCause;
  logic                idRegWrite; // decoded ID bits latched into EX
  logic                idMemRd;
  logic                idRegDst;

  mipsIsaPkg::addrT    nextPc;
  int                  cycleCount;
  int                  causeSeen [0:5];
  logic                coverHole;

  mipsHazardTop uut (
    .clk(clk), .rstN(rstN), .fetchInstr(fetchInstr), .fetchPc(fetchPc),
    .rsData(rsData), .rtData(rtData), .irq(irq), .fetchStall(fetchStall),
    .redirect(redirect), .redirectPc(redirectPc), .exPc(exPc), .exRegWrite(exRegWrite),
    .exMemRd(exMemRd), .exWriteReg(exWriteReg), .hazardCause(hazardCause)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk; // 100 ns period
  end

  task automatic failRun(input string why);
    $display("%s", why);
    $display("Done: errors found");
    $fatal(1, "run stopped on first error");
  endtask

  task automatic checkField(input string name, input logic [31:0] expv, input logic [31:0] actv);
    assert (actv === expv) else begin
      failRun($sformatf("ERR t=%0t %s expected=%h actual=%h", $time, name, expv, actv));
    end
  endtask

  always @(posedge clk) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount > TimeoutCycles) begin
      failRun("timeout: the test loop did not finish within the cycle limit");
    end
  end

  function automatic mipsIsaPkg::instrT drawInstr();
    mipsIsaPkg::regAddrT rs;
    mipsIsaPkg::regAddrT rt;
    mipsIsaPkg::regAddrT rd;
    logic [15:0]         imm;
    mipsIsaPkg::functT   fn;
    mipsIsaPkg::instrT   word;
    rs  = 5'($urandom % 4); // regs 0..3 keep hazards frequent
    rt  = 5'($urandom % 4);
    rd  = 5'($urandom % 4);
    imm = 16'($urandom);
    fn  = ($urandom % 2 == 0) ? `FN_ADD : `FN_SUB;
    case ($urandom % 7)
      0: word = {`OP_LW, rs, rt, imm};
      1: word = {`OP_SW, rs, rt, imm};
      2: word = {`OP_RTYPE, rs, rt, rd, 5'd0, fn};
      3: word = {`OP_ADDI, rs, rt, imm};
      4: word = {`OP_BEQ, rs, rt, imm};
      5: word = {`OP_BNE, rs, rt, imm};
      default: word = {`OP_J, rs, rt, imm}; // index top bits alias the reg fields
    endcase
    return word;
  endfunction

  task automatic resetModel();
    mIfValid    = 1'b0;
    mIfInstr    = `NOP_INSTR;
    mIfPc       = '0;
    mExValid    = 1'b0;
    mExMemRd    = 1'b0;
    mExRegWrite = 1'b0;
    mExRegDst   = 1'b0;
    mExRt       = '0;
    mExRd       = '0;
    mExPc       = '0;
  endtask

  task automatic evalModel();
    mipsIsaPkg::opcodeT  op;
    mipsIsaPkg::regAddrT rs;
    mipsIsaPkg::regAddrT rt;
    mipsIsaPkg::regAddrT exDest;
    mipsIsaPkg::addrT    pc4;
    logic [15:0]         imm;
    logic                isBranch;
    logic                isJump;
    logic                loadUse;
    logic                regBr;
    logic                taken;
    logic                stall;
    op       = mIfInstr[31:26];
    rs       = mIfInstr[25:21];
    rt       = mIfInstr[20:16];
    imm      = mIfInstr[15:0];
    isBranch = mIfValid && (op == `OP_BEQ || op == `OP_BNE);
    isJump   = mIfValid && (op == `OP_J);
    idRegWrite = mIfValid && (op == `OP_RTYPE || op == `OP_LW || op == `OP_ADDI);
    idMemRd    = mIfValid && (op == `OP_LW);
    idRegDst   = mIfValid && (op == `OP_RTYPE); // only R-type writes rd
    exDest   = mExRegDst ? mExRd : mExRt;
    loadUse  = mIfValid && mExValid && mExMemRd && (mExRt == rs || mExRt == rt);
    regBr    = isBranch && mExValid && mExRegWrite && (exDest == rs || exDest == rt);
    taken    = isBranch && ((op == `OP_BEQ) ? (rsData == rtData) : (rsData != rtData));
    stall    = loadUse || regBr;
    expIdExClear = stall && !isJump; // a jump never bubbles ID/EX
    expIfIdClear = !stall && (isJump || irq || taken);
    expHold      = expIdExClear;
    pc4 = mIfPc + 32'd4;
    if (isJump) expRedirPc = {pc4[31:28], mIfInstr[25:0], 2'b00};
    else if (irq) expRedirPc = `IRQ_VECTOR;
    else expRedirPc = pc4 + {{14{imm[15]}}, imm, 2'b00};
    if (expIdExClear && loadUse) expCause = pipeCtrlPkg::loadUse;
    else if (expIdExClear) expCause = pipeCtrlPkg::regBranch;
    else if (expIfIdClear && isJump) expCause = pipeCtrlPkg::jump;
    else if (expIfIdClear && irq) expCause = pipeCtrlPkg::irq;
    else if (expIfIdClear) expCause = pipeCtrlPkg::branchTaken;
    else expCause = pipeCtrlPkg::none;
  endtask

  task automatic compareOutputs();
    checkField("fetchStall", 32'(expHold), 32'(fetchStall));
    checkField("redirect", 32'(expIfIdClear), 32'(redirect));
    if (expIfIdClear) checkField("redirectPc", expRedirPc, redirectPc);
    checkField("hazardCause", 32'(expCause), 32'(hazardCause));
    checkField("exPc", mExPc, exPc);
    checkField("exRegWrite", 32'(mExRegWrite), 32'(exRegWrite));
    checkField("exMemRd", 32'(mExMemRd), 32'(exMemRd));
    checkField("exWriteReg", 32'(mExRegDst ? mExRd : mExRt), 32'(exWriteReg));
  endtask

  // at the clock edge EX takes the old ID contents first, then IF/ID moves
  task automatic advanceModel();
    if (expIdExClear) begin
      mExValid    = 1'b0;
      mExMemRd    = 1'b0;
      mExRegWrite = 1'b0;
      mExRegDst   = 1'b0;
      mExRt       = '0;
      mExRd       = '0;
      mExPc       = '0;
    end else begin
      mExValid    = mIfValid;
      mExMemRd    = idMemRd;
      mExRegWrite = idRegWrite;
      mExRegDst   = idRegDst;
      mExRt       = mIfInstr[20:16];
      mExRd       = mIfInstr[15:11];
      mExPc       = mIfPc;
    end
    if (expIfIdClear) begin
      mIfValid = 1'b0;
      mIfInstr = `NOP_INSTR;
      mIfPc    = '0;
      nextPc   = expRedirPc; // fetch follows the redirect
    end else if (!expHold) begin
      mIfValid = 1'b1;
      mIfInstr = fetchInstr;
      mIfPc    = fetchPc;
      nextPc   = fetchPc + 32'd4;
    end
  endtask

  initial begin
    void'($urandom(Seed));
    rstN       = 1'b0;
    fetchInstr = `NOP_INSTR;
    fetchPc    = '0;
    rsData     = '0;
    rtData     = '0;
    irq        = 1'b0;
    cycleCount = 0;
    coverHole  = 1'b0;
    nextPc     = 32'h0040_0000;
    for (int i = 0; i < 6; i++) causeSeen[i] = 0;
    resetModel();
    repeat (ResetCycles) @(posedge clk);
    #10;
    evalModel(); // bubbles everywhere, irq low
    compareOutputs();
    @(negedge clk);
    rstN = 1'b1;
    for (int cyc = 0; cyc < NumCycles; cyc++) begin
      evalModel(); // stall depends on stage contents only
      if (!expHold) begin
        fetchInstr = drawInstr();
        fetchPc    = nextPc;
      end
      irq    = ($urandom % 100) < 5;
      rsData = 32'($urandom % 3); // narrow range so branches are often taken
      rtData = 32'($urandom % 3);
      #10;
      evalModel();
      compareOutputs();
      causeSeen[int'(expCause)] = causeSeen[int'(expCause)] + 1;
      @(posedge clk);
      advanceModel();
      @(negedge clk);
    end
    for (int i = 0; i < 6; i++) begin
      if (causeSeen[i] == 0) coverHole = 1'b1;
    end
    if (coverHole) begin
      failRun("coverage hole: some hazard cause never occurred in the random stream");
    end else begin
      $display("Done: no errors");
      $finish;
    end
  end

endmodule

// File: tb.f
+incdir+source
source/mipsIsaPkg.sv
source/pipeCtrlPkg.sv
source/pipeIfs.sv
source/ifIdReg.sv
source/idDecode.sv
source/idExReg.sv
source/hazardUnit.sv
source/mipsHazardTop.sv
verification/hazardTb.sv

// File: run.sh
#!/bin/sh
# build the hazard-control testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module hazardTb \
  -f tb.f \
  -o hazardSim

# exit status is nonzero when the run ends in $fatal
./obj_dir/hazardSim
